// File: source/soc_pkg.sv
package soc_pkg;

   typedef logic [31:0] addr_t;             // Byte address
   typedef logic [31:0] data_t;             // Bus data word
   typedef logic [3:0]  byte_lane_t;        // One enable per byte
   typedef logic [2:0]  hsize_t;            // AHB transfer size

   typedef enum logic [1:0] {
      TRANS_IDLE   = 2'b00,                 // No transfer
      TRANS_BUSY   = 2'b01,                 // Master inserting idle cycle
      TRANS_NONSEQ = 2'b10,                 // Single or first beat
      TRANS_SEQ    = 2'b11                  // Following beat
   } htrans_t;

   typedef enum logic [1:0] {
      RESP_OKAY  = 2'b00,
      RESP_ERROR = 2'b01
   } hresp_t;

   typedef enum logic [1:0] {
      IDLE_PHASE,                           // Waiting for an address phase
      DATA_PHASE,                           // Chip enable held until ready
      ERROR_FIRST,                          // Error with hready low
      ERROR_SECOND                          // Error with hready high
   } bridge_state_t;

   typedef enum logic [1:0] {
      SEL_SRAM,
      SEL_TIMER,
      SEL_EXT,
      SEL_NONE                              // Default error slave
   } slave_sel_t;

   typedef struct packed {
      addr_t   haddr;
      htrans_t htrans;
      logic    hwrite;
      hsize_t  hsize;
   } ahb_addr_phase_t;

   typedef struct packed {
      addr_t      addr;
      byte_lane_t bl;
      logic       we;
      logic       ce;                       // Marks a live request
      data_t      wdata;
   } slv_req_t;

   typedef struct packed {
      data_t  rdata;
      hresp_t resp;
      logic   ready;                        // Level, sampled while ce is high
   } slv_rsp_t;

   // Address map on bits 31:28
   localparam logic [3:0] REGION_SRAM  = 4'h0;
   localparam logic [3:0] REGION_TIMER = 4'h4;
   localparam logic [3:0] REGION_EXT   = 4'h8;

   localparam int SRAM_ADDR_BITS   = 12;    // 4 KiB
   localparam int SRAM_WAIT_STATES = 1;

   localparam logic [3:0] TIMER_CTRL_OFS   = 4'h0;
   localparam logic [3:0] TIMER_LOAD_OFS   = 4'h4;
   localparam logic [3:0] TIMER_VALUE_OFS  = 4'h8;
   localparam logic [3:0] TIMER_STATUS_OFS = 4'hC;

endpackage

// File: source/ahb_slave_bridge.sv
`timescale 1ns/1ps

module ahb_slave_bridge (
   input  logic                     HCLK,
   input  logic                     rst_n,
   input  soc_pkg::ahb_addr_phase_t ahb_addr,
   input  soc_pkg::data_t           hwdata,
   output soc_pkg::data_t           hrdata,
   output logic                     hready,
   output soc_pkg::hresp_t          hresp,
   input  logic                     region_valid,
   output soc_pkg::slv_req_t        req,
   input  soc_pkg::slv_rsp_t        rsp
);

   import soc_pkg::*;

   bridge_state_t state, state_nxt;         // Transfer FSM
   addr_t         addr_q;                   // Registered address phase
   byte_lane_t    bl_q;
   logic          we_q;
   logic          accept;                   // Address phase taken this edge

   // Little-endian lane mask from size and low address bits
   function automatic byte_lane_t lane_mask(input hsize_t size, input logic [1:0] ofs);
      byte_lane_t mask;
      case (size)
         3'b000:  mask = 4'b0001 << ofs;              // Byte
         3'b001:  mask = 4'b0011 << {ofs[1], 1'b0};   // Halfword
         default: mask = 4'b1111;                     // Word
      endcase
      return mask;
   endfunction

   assign accept = hready &&
                   (ahb_addr.htrans == TRANS_NONSEQ || ahb_addr.htrans == TRANS_SEQ);

   // AHB-lite response side
   always_comb begin
      hrdata = rsp.rdata;                   // Only sampled on a completing read
      case (state)
         DATA_PHASE: begin
            hready = rsp.ready && (rsp.resp == RESP_OKAY);  // Slave error takes two cycles
            hresp  = rsp.ready ? rsp.resp : RESP_OKAY;
         end
         ERROR_FIRST: begin
            hready = 1'b0;
            hresp  = RESP_ERROR;
         end
         ERROR_SECOND: begin
            hready = 1'b1;
            hresp  = RESP_ERROR;
         end
         default: begin
            hready = 1'b1;                  // Idle bus
            hresp  = RESP_OKAY;
         end
      endcase
   end

   always_comb begin
      case (state)
         DATA_PHASE:  state_nxt = !rsp.ready ? DATA_PHASE :
                                  (rsp.resp == RESP_ERROR) ? ERROR_SECOND : IDLE_PHASE;
         ERROR_FIRST: state_nxt = ERROR_SECOND;
         default:     state_nxt = IDLE_PHASE;
      endcase
      if (accept) begin
         state_nxt = region_valid ? DATA_PHASE : ERROR_FIRST; // Unmapped skips chip enable
      end
   end

   always_ff @(posedge HCLK) begin
      if (!rst_n) begin
         state <= IDLE_PHASE;
      end else begin
         state <= state_nxt;
      end
   end

   // Address phase payload
   always_ff @(posedge HCLK) begin
      if (accept) begin
         addr_q <= ahb_addr.haddr;
         bl_q   <= lane_mask(ahb_addr.hsize, ahb_addr.haddr[1:0]);
         we_q   <= ahb_addr.hwrite;
      end
   end

   assign req = '{addr:  addr_q,
                  bl:    bl_q,
                  we:    we_q,
                  ce:    (state == DATA_PHASE),
                  wdata: hwdata};           // Write data comes live in the data phase

   // Stalled request must be held stable
   ce_hold_a: assert property (@(posedge HCLK) disable iff (!rst_n)
      req.ce && !rsp.ready |=> req.ce && $stable(req.addr))
      else $error("Chip enable or address dropped before ready");

endmodule

// File: source/slave_decoder.sv
`timescale 1ns/1ps

module slave_decoder (
   input  soc_pkg::slv_req_t req,
   output soc_pkg::slv_rsp_t rsp,
   input  soc_pkg::addr_t    addr_phase,
   output logic              region_valid,
   output soc_pkg::slv_req_t sram_req,
   input  soc_pkg::slv_rsp_t sram_rsp,
   output soc_pkg::slv_req_t timer_req,
   input  soc_pkg::slv_rsp_t timer_rsp,
   output soc_pkg::slv_req_t ext_req,
   input  soc_pkg::slv_rsp_t ext_rsp
);

   import soc_pkg::*;

   slave_sel_t sel;                         // Target of the registered request

   function automatic slave_sel_t region_sel(input addr_t a);
      case (a[31:28])
         REGION_SRAM:  return SEL_SRAM;
         REGION_TIMER: return SEL_TIMER;
         REGION_EXT:   return SEL_EXT;
         default:      return SEL_NONE;
      endcase
   endfunction

   assign sel          = region_sel(req.addr);
   assign region_valid = (region_sel(addr_phase) != SEL_NONE);  // Live address phase

   // Same request to all, chip enable only at the selected one
   always_comb begin
      sram_req     = req;
      timer_req    = req;
      ext_req      = req;
      sram_req.ce  = req.ce && (sel == SEL_SRAM);
      timer_req.ce = req.ce && (sel == SEL_TIMER);
      ext_req.ce   = req.ce && (sel == SEL_EXT);
   end

   always_comb begin
      case (sel)
         SEL_SRAM:  rsp = sram_rsp;
         SEL_TIMER: rsp = timer_rsp;
         SEL_EXT:   rsp = ext_rsp;
         default:   rsp = '{rdata: '0, resp: RESP_ERROR, ready: 1'b1};  // Default slave
      endcase
   end

   // Unmapped accesses end in the bridge, never as a chip enable here
   always_comb begin
      ce_mapped_a: assert final (!(req.ce === 1'b1 && sel == SEL_NONE))
         else $error("Chip enable raised for an unmapped region");
   end

endmodule

// File: source/sram_slave.sv
`timescale 1ns/1ps

module sram_slave #(
   parameter int ADDR_BITS   = 12,          // Byte address width
   parameter int WAIT_STATES = 1            // Extra cycles before ready
) (
   input  logic              HCLK,
   input  logic              rst_n,
   input  soc_pkg::slv_req_t req,
   output soc_pkg::slv_rsp_t rsp
);

   import soc_pkg::*;

   localparam int WORDS = 2 ** (ADDR_BITS - 2);
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   data_t                  mem [WORDS];     // Word array
   logic [ADDR_BITS-3:0]   word_idx;
   logic [CNT_W-1:0]       wait_cnt;        // Chip enable cycles so far
   logic                   ready;

   assign word_idx = req.addr[ADDR_BITS-1:2];
   assign ready    = req.ce && (wait_cnt == CNT_W'(WAIT_STATES));

   always_ff @(posedge HCLK) begin
      if (!rst_n) begin
         wait_cnt <= '0;
      end else if (req.ce && !ready) begin
         wait_cnt <= wait_cnt + 1'b1;       // Still waiting
      end else begin
         wait_cnt <= '0;                    // Done or idle
      end
   end

   // Lane writes on the completing cycle only
   always_ff @(posedge HCLK) begin
      if (ready && req.we) begin
         for (int i = 0; i < 4; i++) begin
            if (req.bl[i]) begin
               mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
            end
         end
      end
   end

   assign rsp = '{rdata: mem[word_idx], resp: RESP_OKAY, ready: ready};  // Whole word back

   // Bridge lane mask must select something on writes
   lanes_a: assert property (@(posedge HCLK) disable iff (!rst_n)
      req.ce && req.we |-> req.bl != '0)
      else $error("SRAM write with no byte lanes");

endmodule

// File: source/timer_slave.sv
`timescale 1ns/1ps

module timer_slave (
   input  logic              HCLK,
   input  logic              rst_n,
   input  soc_pkg::slv_req_t req,
   output soc_pkg::slv_rsp_t rsp
);

   import soc_pkg::*;

   logic       ctrl_en;                     // CTRL bit 0
   data_t      load_q;                      // Reload value
   data_t      value_q;                     // Current count
   logic       expired;                     // STATUS bit 0, sticky
   logic [3:0] reg_ofs;
   logic       wr;
   data_t      rd_data;

   assign reg_ofs = req.addr[3:0];
   assign wr      = req.ce && req.we;       // Always ready, so writes land at once

   always_ff @(posedge HCLK) begin
      if (!rst_n) begin
         ctrl_en <= 1'b0;
         load_q  <= '0;
         value_q <= '0;
         expired <= 1'b0;
      end else begin
         if (wr && reg_ofs == TIMER_CTRL_OFS) begin
            ctrl_en <= req.wdata[0];
         end
         if (wr && reg_ofs == TIMER_STATUS_OFS && req.wdata[0]) begin
            expired <= 1'b0;                // Write one to clear
         end
         if (wr && reg_ofs == TIMER_LOAD_OFS) begin
            load_q  <= req.wdata;
            value_q <= req.wdata;           // Restart from the new value
         end else if (ctrl_en) begin
            if (value_q == '0) begin
               value_q <= load_q;           // Reload
               expired <= 1'b1;             // Expiry beats a same-cycle clear
            end else begin
               value_q <= value_q - 1'b1;
            end
         end
      end
   end

   // Register read mux, VALUE writes are ignored above
   always_comb begin
      case (reg_ofs)
         TIMER_CTRL_OFS:   rd_data = {31'b0, ctrl_en};
         TIMER_LOAD_OFS:   rd_data = load_q;
         TIMER_VALUE_OFS:  rd_data = value_q;
         TIMER_STATUS_OFS: rd_data = {31'b0, expired};
         default:          rd_data = '0;
      endcase
   end

   assign rsp = '{rdata: rd_data, resp: RESP_OKAY, ready: req.ce};  // No wait states

endmodule

// File: source/soc_top.sv
`timescale 1ns/1ps

module soc_top (
   input  logic                     HCLK,
   input  logic                     rst_n,
   input  soc_pkg::ahb_addr_phase_t ahb_addr,
   input  soc_pkg::data_t           hwdata,
   output soc_pkg::data_t           hrdata,
   output logic                     hready,
   output soc_pkg::hresp_t          hresp,
   output soc_pkg::slv_req_t        tb_req,   // External memory port
   input  soc_pkg::slv_rsp_t        tb_rsp
);

   soc_pkg::slv_req_t bus_req;              // Bridge to decoder
   soc_pkg::slv_rsp_t bus_rsp;
   soc_pkg::slv_req_t sram_req;
   soc_pkg::slv_rsp_t sram_rsp;
   soc_pkg::slv_req_t timer_req;
   soc_pkg::slv_rsp_t timer_rsp;
   logic              region_valid;         // Address phase hits a slave

   ahb_slave_bridge u_bridge (
      .HCLK(HCLK), .rst_n(rst_n), .ahb_addr(ahb_addr), .hwdata(hwdata),
      .hrdata(hrdata), .hready(hready), .hresp(hresp),
      .region_valid(region_valid), .req(bus_req), .rsp(bus_rsp)
   );

   slave_decoder u_decoder (
      .req(bus_req), .rsp(bus_rsp), .addr_phase(ahb_addr.haddr),
      .region_valid(region_valid),
      .sram_req(sram_req), .sram_rsp(sram_rsp),
      .timer_req(timer_req), .timer_rsp(timer_rsp),
      .ext_req(tb_req), .ext_rsp(tb_rsp)   // Straight out to the testbench memory
   );

   sram_slave #(
      .ADDR_BITS(soc_pkg::SRAM_ADDR_BITS), .WAIT_STATES(soc_pkg::SRAM_WAIT_STATES)
   ) u_sram (
      .HCLK(HCLK), .rst_n(rst_n), .req(sram_req), .rsp(sram_rsp)
   );

   timer_slave u_timer (.HCLK(HCLK), .rst_n(rst_n), .req(timer_req), .rsp(timer_rsp));

endmodule

// File: dv/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

   import soc_pkg::*;

   logic            HCLK = 1'b0;
   logic            rst_n;
   ahb_addr_phase_t ahb_addr;
   data_t           hwdata;
   data_t           hrdata;
   logic            hready;
   hresp_t          hresp;
   slv_req_t        tb_req;
   slv_rsp_t        tb_rsp;

   int         errors;
   int         timeouts;
   int         stall_cnt;                   // Data phase cycles with hready low
   logic       first_hready;                // First data phase cycle
   hresp_t     first_hresp;
   logic       ext_ce_seen;                 // External chip enable during a transfer
   data_t      sram_ref [1024];             // Expected SRAM words
   data_t      ext_mem [256];               // External memory model
   int         ext_wait;                    // Ready-low cycles still to go
   int         ext_wait_armed;
   int         ext_stalls_done;             // Stalls of the last completed access
   addr_t      ext_last_addr;               // Last write seen by the model
   byte_lane_t ext_last_bl;
   data_t      ext_last_wdata;

   soc_top u_soc_top (
      .HCLK(HCLK), .rst_n(rst_n), .ahb_addr(ahb_addr), .hwdata(hwdata), .hrdata(hrdata),
      .hready(hready), .hresp(hresp), .tb_req(tb_req), .tb_rsp(tb_rsp)
   );

   always #4 HCLK = ~HCLK;                  // 8 ns period

   // External memory answers after 0 to 3 ready-low cycles
   always @(negedge HCLK) begin
      if (!tb_req.ce) begin
         tb_rsp.ready   = 1'b0;
         ext_wait       = $urandom_range(3, 0);
         ext_wait_armed = ext_wait;
      end else if (ext_wait == 0) begin
         tb_rsp.ready = 1'b1;
         tb_rsp.rdata = ext_mem[tb_req.addr[9:2]];
      end else begin
         ext_wait--;
      end
   end

   always @(posedge HCLK) begin
      if (tb_req.ce && tb_rsp.ready) begin
         ext_stalls_done = ext_wait_armed;
         if (tb_req.we) begin
            ext_last_addr  = tb_req.addr;
            ext_last_bl    = tb_req.bl;
            ext_last_wdata = tb_req.wdata;
            for (int i = 0; i < 4; i++) begin
               if (tb_req.bl[i]) ext_mem[tb_req.addr[9:2]][8*i +: 8] = tb_req.wdata[8*i +: 8];
            end
         end
      end
   end

   // Little-endian lanes for a given size and offset
   function automatic byte_lane_t lanes_for(input hsize_t size, input logic [1:0] ofs);
      if (size == 3'b000) return byte_lane_t'(1) << ofs;
      if (size == 3'b001) return ofs[1] ? 4'b1100 : 4'b0011;
      return 4'b1111;
   endfunction

   function automatic data_t merge_lanes(input data_t old, input data_t nw, input byte_lane_t bl);
      data_t res;
      for (int i = 0; i < 4; i++) res[8*i +: 8] = bl[i] ? nw[8*i +: 8] : old[8*i +: 8];
      return res;
   endfunction

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_resp(input string name, input hresp_t exp, input hresp_t act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_lanes(input string name, input byte_lane_t exp, input byte_lane_t act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         errors++;
      end
   endtask

   // One AHB-lite transfer, entered and left on a falling edge
   task automatic bus_transfer(input addr_t addr, input logic write, input hsize_t size,
                               input data_t wdata, output data_t rdata, output hresp_t resp);
      int cycles;
      rdata    = '0;
      resp     = RESP_ERROR;
      cycles   = 0;
      ahb_addr = '{haddr: addr, htrans: TRANS_NONSEQ, hwrite: write, hsize: size};
      #1;
      while (!hready) begin                 // Bus still busy
         cycles++;
         if (cycles > 20) begin
            $display("Timeout: address phase at %h was never accepted", addr);
            timeouts++;
            ahb_addr.htrans = TRANS_IDLE;
            return;
         end
         @(negedge HCLK);
         #1;
      end
      @(negedge HCLK);                      // Accepted, data phase
      ahb_addr.htrans = TRANS_IDLE;
      hwdata          = wdata;
      stall_cnt       = 0;
      #1;
      first_hready = hready;
      first_hresp  = hresp;
      ext_ce_seen  = ext_ce_seen | tb_req.ce;
      while (!hready) begin
         stall_cnt++;
         if (stall_cnt > 20) begin
            $display("Timeout: hready stayed low in the data phase at %h", addr);
            timeouts++;
            return;
         end
         @(negedge HCLK);
         #1;
         ext_ce_seen = ext_ce_seen | tb_req.ce;
      end
      rdata = hrdata;                       // Completes on the next rising edge
      resp  = hresp;
      @(negedge HCLK);
   endtask

   task automatic ahb_write(input addr_t addr, input hsize_t size, input data_t wdata,
                            output hresp_t resp);
      data_t unused;
      bus_transfer(addr, 1'b1, size, wdata, unused, resp);
   endtask

   task automatic ahb_read(input addr_t addr, output data_t rdata, output hresp_t resp);
      bus_transfer(addr, 1'b0, 3'b010, '0, rdata, resp);
   endtask

   task automatic test_reset();
      data_t  rd;
      hresp_t rsp;
      check_flag("reset hready", 1'b1, hready);
      check_resp("reset hresp", RESP_OKAY, hresp);
      check_flag("reset tb_req.ce", 1'b0, tb_req.ce);
      for (int ofs = 0; ofs < 16; ofs += 4) begin
         ahb_read({REGION_TIMER, 28'(ofs)}, rd, rsp);
         check_resp("reset timer resp", RESP_OKAY, rsp);
         check_data("reset timer register", 32'h0, rd);
      end
   endtask

   task automatic test_sram_words();
      addr_t  addrs [$];
      addr_t  a;
      data_t  d;
      data_t  rd;
      hresp_t rsp;
      for (int i = 0; i < 16; i++) begin
         a = addr_t'($urandom_range(1023, 0)) << 2;
         d = $urandom();
         ahb_write(a, 3'b010, d, rsp);
         check_resp("sram word write", RESP_OKAY, rsp);
         check_flag("sram two data cycles", 1'b1, stall_cnt == SRAM_WAIT_STATES);
         sram_ref[a[11:2]] = d;
         addrs.push_back(a);
      end
      foreach (addrs[i]) begin
         ahb_read(addrs[i], rd, rsp);
         check_resp("sram word read", RESP_OKAY, rsp);
         check_data("sram word read", sram_ref[addrs[i][11:2]], rd);
      end
   endtask

   task automatic test_sram_lanes();
      hsize_t     sizes [6] = '{3'b000, 3'b000, 3'b000, 3'b000, 3'b001, 3'b001};
      logic [1:0] offs [6]  = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2};
      addr_t      base;
      data_t      expected;
      data_t      d;
      data_t      rd;
      hresp_t     rsp;
      base     = 32'h0000_0200;
      expected = 32'h1122_3344;
      ahb_write(base, 3'b010, expected, rsp);
      for (int i = 0; i < 6; i++) begin
         d = $urandom();
         ahb_write(base + offs[i], sizes[i], d, rsp);
         check_resp("sram lane write", RESP_OKAY, rsp);
         expected = merge_lanes(expected, d, lanes_for(sizes[i], offs[i]));
         ahb_read(base, rd, rsp);
         check_data("sram lane read", expected, rd);
      end
      sram_ref[base[11:2]] = expected;
   endtask

   task automatic test_ext_port();
      data_t  expected [4];
      addr_t  a;
      data_t  d;
      data_t  rd;
      hresp_t rsp;
      for (int i = 0; i < 5; i++) begin
         a = (i < 4) ? {REGION_EXT, 28'(4 * i)} : {REGION_EXT, 28'h6};  // Last is a byte
         d = $urandom();
         ahb_write(a, (i < 4) ? 3'b010 : 3'b000, d, rsp);
         check_resp("ext write resp", RESP_OKAY, rsp);
         check_addr("ext write addr", a, ext_last_addr);
         check_lanes("ext write lanes", lanes_for((i < 4) ? 3'b010 : 3'b000, a[1:0]), ext_last_bl);
         check_data("ext write data", d, ext_last_wdata);
         if (i < 4) expected[i] = d;
         else expected[1] = merge_lanes(expected[1], d, lanes_for(3'b000, a[1:0]));
      end
      for (int i = 0; i < 4; i++) begin
         ahb_read({REGION_EXT, 28'(4 * i)}, rd, rsp);
         check_resp("ext read resp", RESP_OKAY, rsp);
         check_data("ext read data", expected[i], rd);
         check_flag("ext back-pressure", 1'b1, stall_cnt == ext_stalls_done);
      end
      // Reads arrive with write enable low, so the model saw no new write
      check_addr("ext read write enable", {REGION_EXT, 28'h6}, ext_last_addr);
   endtask

   task automatic test_timer();
      data_t  rd;
      data_t  value;
      hresp_t rsp;
      int     polls;
      ahb_write({REGION_TIMER, 24'h0, TIMER_LOAD_OFS}, 3'b010, 32'd5, rsp);
      ahb_write({REGION_TIMER, 24'h0, TIMER_CTRL_OFS}, 3'b010, 32'd1, rsp);
      polls = 0;
      rd    = '0;
      while (rd !== 32'd1) begin            // Poll for expiry
         polls++;
         if (polls > 40) begin
            $display("Timeout: timer STATUS never showed expiry");
            timeouts++;
            break;
         end
         ahb_read({REGION_TIMER, 24'h0, TIMER_VALUE_OFS}, value, rsp);
         check_flag("timer value within load", 1'b1, value <= 32'd5);
         ahb_read({REGION_TIMER, 24'h0, TIMER_STATUS_OFS}, rd, rsp);
      end
      ahb_write({REGION_TIMER, 24'h0, TIMER_CTRL_OFS}, 3'b010, 32'd0, rsp);  // Stop first
      ahb_write({REGION_TIMER, 24'h0, TIMER_STATUS_OFS}, 3'b010, 32'd1, rsp);
      ahb_read({REGION_TIMER, 24'h0, TIMER_STATUS_OFS}, rd, rsp);
      check_data("timer status cleared", 32'd0, rd);
   endtask

   task automatic test_unmapped();
      addr_t  bad [2] = '{32'h2000_0010, 32'hC000_0000};
      data_t  rd;
      hresp_t rsp;
      ext_ce_seen = 1'b0;
      for (int i = 0; i < 2; i++) begin     // Read then write
         bus_transfer(bad[i], i[0], 3'b010, 32'hDEAD_BEEF, rd, rsp);
         check_flag("unmapped first hready", 1'b0, first_hready);
         check_resp("unmapped first hresp", RESP_ERROR, first_hresp);
         check_flag("unmapped two cycles", 1'b1, stall_cnt == 1);
         check_resp("unmapped second hresp", RESP_ERROR, rsp);
      end
      check_flag("unmapped tb_req.ce", 1'b0, ext_ce_seen);
      ahb_write(32'h0000_0040, 3'b010, 32'h5A5A_0F0F, rsp);
      ahb_read(32'h0000_0040, rd, rsp);
      check_resp("sram after error", RESP_OKAY, rsp);
      check_data("sram after error", 32'h5A5A_0F0F, rd);
   endtask

   initial begin
      void'($urandom(73746));
      rst_n       = 1'b0;
      ahb_addr    = '{haddr: '0, htrans: TRANS_IDLE, hwrite: 1'b0, hsize: 3'b010};
      hwdata      = '0;
      tb_rsp      = '{rdata: '0, resp: RESP_OKAY, ready: 1'b0};
      errors      = 0;
      timeouts    = 0;
      ext_ce_seen = 1'b0;
      repeat (3) @(posedge HCLK);
      @(negedge HCLK);
      rst_n = 1'b1;
      test_reset();
      test_sram_words();
      test_sram_lanes();
      test_ext_port();
      test_timer();
      test_unmapped();
      $display("errors=%0d timeouts=%0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: all.f
source/soc_pkg.sv
source/ahb_slave_bridge.sv
source/slave_decoder.sv
source/sram_slave.sv
source/timer_slave.sv
source/soc_top.sv
dv/soc_tb.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  - source/soc_pkg.sv
  - source/ahb_slave_bridge.sv
  - source/slave_decoder.sv
  - source/sram_slave.sv
  - source/timer_slave.sv
  - source/soc_top.sv
  - target: test
    files:
      - dv/soc_tb.sv
